/* design/bitser_pkg.sv */
package bitser_pkg;

   localparam int XLEN  = 32;
   localparam int CNT_W = 5;

   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

   // RV32I major opcodes and funct7 values used by the core
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] F7_BASE    = 7'b0000000;
   localparam logic [6:0] F7_SUB     = 7'b0100000;

   typedef enum logic [1:0] {
      st_fetch,
      st_exec,
      st_retire
   } bitser_state_e;

   typedef enum logic [2:0] {
      op_addi,
      op_add,
      op_sub,
      op_xor,
      op_or,
      op_and,
      op_lui,
      op_illegal
   } bitser_op_e;

   // Decoded instruction, held stable from capture to the next capture
   typedef struct packed {
      bitser_op_e      opcode;
      logic [4:0]      rd;
      logic [4:0]      rs1;
      logic [4:0]      rs2;
      logic [XLEN-1:0] imm;
   } bitser_ctrl_t;

   typedef struct packed {
      logic [4:0]      rd_addr;
      logic [XLEN-1:0] data;
   } bitser_retire_t;

endpackage

/* design/bitser_state.sv */
`timescale 1ns/1ns

module bitser_state (
   input  logic                         clk,
   input  logic                         i_reset,
   input  logic                         i_ibus_ack,
   input  logic                         i_cnt_done,
   output logic                         o_ibus_cyc,
   output logic [bitser_pkg::XLEN-1:0]  o_ibus_adr,
   output logic                         o_capture,
   output logic                         o_cnt_start,
   output logic                         o_exec,
   output logic                         o_wr
);

   bitser_pkg::bitser_state_e   state;
   logic [bitser_pkg::XLEN-1:0] pc;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state <= bitser_pkg::st_fetch;
         pc    <= bitser_pkg::RESET_PC;
      end else begin
         case (state)
            bitser_pkg::st_fetch: begin
               if (i_ibus_ack) begin
                  state <= bitser_pkg::st_exec;
               end
            end
            bitser_pkg::st_exec: begin
               // Leave after the bit at index 31
               if (i_cnt_done) begin
                  state <= bitser_pkg::st_retire;
               end
            end
            bitser_pkg::st_retire: begin
               state <= bitser_pkg::st_fetch;
               pc    <= pc + 32'd4;
            end
            default: begin
               state <= bitser_pkg::st_fetch;
            end
         endcase
      end
   end

   assign o_ibus_cyc  = (state == bitser_pkg::st_fetch);
   assign o_ibus_adr  = pc;
   assign o_capture   = o_ibus_cyc && i_ibus_ack;
   assign o_cnt_start = o_capture;
   assign o_exec      = (state == bitser_pkg::st_exec);
   assign o_wr        = (state == bitser_pkg::st_retire);

   // Request holds with a stable address until it is acknowledged
   assert property (@(posedge clk) disable iff (i_reset)
      (o_ibus_cyc && !i_ibus_ack) |=> (o_ibus_cyc && $stable(o_ibus_adr)));

   // Counter and FSM together give exactly 32 execute cycles then one retire
   assert property (@(posedge clk) disable iff (i_reset)
      o_cnt_start |=> (o_exec [*32] ##1 o_wr));

endmodule

/* design/bitser_count.sv */
`timescale 1ns/1ns

module bitser_count (
   input  logic                          clk,
   input  logic                          i_reset,
   input  logic                          i_start,
   input  logic                          i_en,
   output logic [bitser_pkg::CNT_W-1:0]  o_cnt,
   output logic                          o_cnt_done
);

   always_ff @(posedge clk) begin
      if (i_reset || i_start) begin
         o_cnt <= '0;
      end else if (i_en) begin
         // Wraps back to zero after bit 31
         o_cnt <= o_cnt + 1'b1;
      end
   end

   assign o_cnt_done = &o_cnt;

   // Between words the counter rests at zero
   assert property (@(posedge clk) disable iff (i_reset)
      !i_en |-> (o_cnt == '0));

endmodule

/* design/bitser_decode.sv */
`timescale 1ns/1ns

module bitser_decode (
   input  logic                          clk,
   input  logic                          i_reset,
   input  logic                          i_capture,
   input  logic [bitser_pkg::XLEN-1:0]   i_rdt,
   output bitser_pkg::bitser_ctrl_t      o_ctrl
);

   logic [bitser_pkg::XLEN-1:0] insn;
   logic [6:0]                  opc;
   logic [2:0]                  funct3;
   logic [6:0]                  funct7;
   bitser_pkg::bitser_op_e      op;

   // All-zero word decodes as illegal
   always_ff @(posedge clk) begin
      if (i_reset) begin
         insn <= '0;
      end else if (i_capture) begin
         insn <= i_rdt;
      end
   end

   assign opc    = insn[6:0];
   assign funct3 = insn[14:12];
   assign funct7 = insn[31:25];

   always_comb begin
      op = bitser_pkg::op_illegal;
      case (opc)
         bitser_pkg::OPC_OP_IMM: begin
            if (funct3 == 3'b000) begin
               op = bitser_pkg::op_addi;
            end
         end
         bitser_pkg::OPC_OP: begin
            if (funct7 == bitser_pkg::F7_BASE) begin
               case (funct3)
                  3'b000:  op = bitser_pkg::op_add;
                  3'b100:  op = bitser_pkg::op_xor;
                  3'b110:  op = bitser_pkg::op_or;
                  3'b111:  op = bitser_pkg::op_and;
                  default: op = bitser_pkg::op_illegal;
               endcase
            end else if (funct7 == bitser_pkg::F7_SUB && funct3 == 3'b000) begin
               op = bitser_pkg::op_sub;
            end
         end
         bitser_pkg::OPC_LUI: op = bitser_pkg::op_lui;
         default:             op = bitser_pkg::op_illegal;
      endcase
   end

   assign o_ctrl.opcode = op;
   assign o_ctrl.rd     = insn[11:7];
   assign o_ctrl.rs1    = insn[19:15];
   assign o_ctrl.rs2    = insn[24:20];
   // U-type for LUI, sign-extended I-type otherwise
   assign o_ctrl.imm    = (opc == bitser_pkg::OPC_LUI) ? {insn[31:12], 12'b0}
                                                       : {{20{insn[31]}}, insn[31:20]};

endmodule

/* design/bitser_alu.sv */
`timescale 1ns/1ns

module bitser_alu (
   input  logic                          clk,
   input  logic                          i_reset,
   input  logic                          i_en,
   input  logic                          i_first,
   input  bitser_pkg::bitser_ctrl_t      i_ctrl,
   input  logic [bitser_pkg::CNT_W-1:0]  i_cnt,
   input  logic                          i_rs1,
   input  logic                          i_rs2,
   output logic [bitser_pkg::XLEN-1:0]   o_result
);

   logic is_sub;
   logic use_imm;
   logic op_b;
   logic op_b_add;
   logic carry_q;
   logic cin;
   logic sum;
   logic cout;
   logic res_bit;

   assign is_sub  = (i_ctrl.opcode == bitser_pkg::op_sub);
   assign use_imm = (i_ctrl.opcode == bitser_pkg::op_addi) ||
                    (i_ctrl.opcode == bitser_pkg::op_lui);
   assign op_b     = use_imm ? i_ctrl.imm[i_cnt] : i_rs2;
   assign op_b_add = op_b ^ is_sub;

   // Carry flop is stored relative to the subtract carry-in, so clearing it
   // gives cin of 0 for add and 1 for sub on bit 0
   assign cin  = carry_q ^ is_sub;
   assign sum  = i_rs1 ^ op_b_add ^ cin;
   assign cout = (i_rs1 & op_b_add) | (i_rs1 & cin) | (op_b_add & cin);

   always_comb begin
      case (i_ctrl.opcode)
         bitser_pkg::op_xor: res_bit = i_rs1 ^ op_b;
         bitser_pkg::op_or:  res_bit = i_rs1 | op_b;
         bitser_pkg::op_and: res_bit = i_rs1 & op_b;
         bitser_pkg::op_lui: res_bit = op_b;
         default:            res_bit = sum;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset || i_first) begin
         carry_q <= 1'b0;
      end else if (i_en) begin
         carry_q <= cout ^ is_sub;
      end
   end

   // LSB first, so bit 0 lands at the bottom after 32 shifts
   always_ff @(posedge clk) begin
      if (i_en) begin
         o_result <= {res_bit, o_result[bitser_pkg::XLEN-1:1]};
      end
   end

endmodule

/* design/bitser_regfile.sv */
`timescale 1ns/1ns

module bitser_regfile (
   input  logic                          clk,
   input  logic                          i_reset,
   input  bitser_pkg::bitser_ctrl_t      i_ctrl,
   input  logic [bitser_pkg::CNT_W-1:0]  i_cnt,
   input  logic                          i_wr,
   input  logic [bitser_pkg::XLEN-1:0]   i_wdata,
   output logic                          o_rs1,
   output logic                          o_rs2
);

   logic [bitser_pkg::XLEN-1:0] regs [32];
   logic                        we;

   // Illegal words and x0 targets leave the array untouched
   assign we = i_wr && (i_ctrl.rd != 5'd0) &&
               (i_ctrl.opcode != bitser_pkg::op_illegal);

   always_ff @(posedge clk) begin
      if (we && !i_reset) begin
         regs[i_ctrl.rd] <= i_wdata;
      end
   end

   // One bit per cycle, x0 forced to zero
   assign o_rs1 = (i_ctrl.rs1 != 5'd0) && regs[i_ctrl.rs1][i_cnt];
   assign o_rs2 = (i_ctrl.rs2 != 5'd0) && regs[i_ctrl.rs2][i_cnt];

   // Each instruction writes at most once
   assert property (@(posedge clk) disable iff (i_reset)
      we |=> !we);

endmodule

/* design/bitser_top.sv */
`timescale 1ns/1ns

module bitser_top (
   input  logic                          clk,
   input  logic                          i_reset,
   input  logic [bitser_pkg::XLEN-1:0]   i_ibus_rdt,
   input  logic                          i_ibus_ack,
   output logic [bitser_pkg::XLEN-1:0]   o_ibus_adr,
   output logic                          o_ibus_cyc,
   output logic                          o_retire_valid,
   output bitser_pkg::bitser_retire_t    o_retire
);

   bitser_pkg::bitser_ctrl_t     ctrl;
   logic [bitser_pkg::CNT_W-1:0] cnt;
   logic [bitser_pkg::XLEN-1:0]  result;
   logic                         capture;
   logic                         cnt_start;
   logic                         cnt_done;
   logic                         exec;
   logic                         wr;
   logic                         rs1;
   logic                         rs2;

   bitser_state u_state (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_ibus_ack  (i_ibus_ack),
      .i_cnt_done  (cnt_done),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_ibus_adr  (o_ibus_adr),
      .o_capture   (capture),
      .o_cnt_start (cnt_start),
      .o_exec      (exec),
      .o_wr        (wr)
   );

   bitser_count u_count (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_start    (cnt_start),
      .i_en       (exec),
      .o_cnt      (cnt),
      .o_cnt_done (cnt_done)
   );

   bitser_decode u_decode (
      .clk       (clk),
      .i_reset   (i_reset),
      .i_capture (capture),
      .i_rdt     (i_ibus_rdt),
      .o_ctrl    (ctrl)
   );

   bitser_alu u_alu (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_en     (exec),
      .i_first  (cnt_start),
      .i_ctrl   (ctrl),
      .i_cnt    (cnt),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .o_result (result)
   );

   bitser_regfile u_regfile (
      .clk     (clk),
      .i_reset (i_reset),
      .i_ctrl  (ctrl),
      .i_cnt   (cnt),
      .i_wr    (wr),
      .i_wdata (result),
      .o_rs1   (rs1),
      .o_rs2   (rs2)
   );

   // Same qualification as the register file write enable
   assign o_retire_valid   = wr && (ctrl.rd != 5'd0) &&
                             (ctrl.opcode != bitser_pkg::op_illegal);
   assign o_retire.rd_addr = ctrl.rd;
   assign o_retire.data    = result;

endmodule

/* tb/bitser_tb.sv */
`timescale 1ns/1ns

module bitser_tb;

   localparam int NUM_TESTS  = 20;
   localparam int FIELDS     = 4;
   localparam int TIMEOUT    = 100;
   localparam int RETIRE_LAT = 33;

   logic                        clk;
   logic                        i_reset;
   logic [bitser_pkg::XLEN-1:0] i_ibus_rdt;
   logic                        i_ibus_ack;
   logic [bitser_pkg::XLEN-1:0] o_ibus_adr;
   logic                        o_ibus_cyc;
   logic                        o_retire_valid;
   bitser_pkg::bitser_retire_t  o_retire;

   // Per test: word, retire flag, rd, value
   logic [31:0] stim [NUM_TESTS*FIELDS];
   logic [31:0] lfsr;
   int          errors;
   int          passed;
   int          failed;
   bit          aborted;

   bitser_top i_dut (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_ibus_rdt     (i_ibus_rdt),
      .i_ibus_ack     (i_ibus_ack),
      .o_ibus_adr     (o_ibus_adr),
      .o_ibus_cyc     (o_ibus_cyc),
      .o_retire_valid (o_retire_valid),
      .o_retire       (o_retire)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0]) begin
         next = next ^ 32'h8020_0003;
      end
      return next;
   endfunction

   task automatic draw_bits(input int n, output int value);
      value = 0;
      for (int b = 0; b < n; b++) begin
         value = (value << 1) | int'(lfsr[0]);
         lfsr  = lfsr_next(lfsr);
      end
   endtask

   task automatic report_failure(input string what);
      $display("Error: %s", what);
      errors++;
   endtask

   task automatic compare_fetch_addr(input logic [bitser_pkg::XLEN-1:0] got,
                                     input logic [bitser_pkg::XLEN-1:0] exp);
      if (got !== exp) begin
         $display("Mismatch o_ibus_adr: got %h, expected %h", got, exp);
         errors++;
      end
   endtask

   task automatic compare_retire(input bitser_pkg::bitser_retire_t got,
                                 input bitser_pkg::bitser_retire_t exp);
      if (got !== exp) begin
         $display("Mismatch o_retire: got rd_addr %h data %h, expected rd_addr %h data %h",
                  got.rd_addr, got.data, exp.rd_addr, exp.data);
         errors++;
      end
   endtask

   task automatic run_test(input int idx);
      logic [31:0]                 word;
      logic                        want_retire;
      bitser_pkg::bitser_retire_t  exp_ret;
      logic [bitser_pkg::XLEN-1:0] exp_adr;
      int                          delay;
      int                          cycles;
      int                          errors_before;
      bit                          seen;

      word            = stim[idx*FIELDS];
      want_retire     = stim[idx*FIELDS+1][0];
      exp_ret.rd_addr = stim[idx*FIELDS+2][4:0];
      exp_ret.data    = stim[idx*FIELDS+3];
      exp_adr         = bitser_pkg::RESET_PC + 32'(4 * idx);
      errors_before   = errors;

      seen = 1'b0;
      for (int t = 0; t < TIMEOUT && !seen; t++) begin
         @(negedge clk);
         if (o_retire_valid) begin
            report_failure("retire pulse while waiting for a fetch request");
         end
         seen = o_ibus_cyc;
      end
      if (!seen) begin
         $display("Timeout: test %0d never saw a fetch request", idx);
         failed++;
         aborted = 1'b1;
         return;
      end
      compare_fetch_addr(o_ibus_adr, exp_adr);

      // Hold off the acknowledge for 0 to 3 cycles
      draw_bits(2, delay);
      for (int d = 0; d < delay; d++) begin
         @(negedge clk);
         if (!o_ibus_cyc) begin
            report_failure("fetch request dropped before the acknowledge");
         end
         compare_fetch_addr(o_ibus_adr, exp_adr);
      end

      @(posedge clk);
      i_ibus_ack <= 1'b1;
      i_ibus_rdt <= word;
      @(posedge clk);
      i_ibus_ack <= 1'b0;

      // Falling edges counted from the acknowledge edge
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
         if (o_retire_valid) begin
            seen = 1'b1;
            if (!want_retire) begin
               report_failure("retire pulse for an instruction that writes nothing");
            end else begin
               if (cycles != RETIRE_LAT) begin
                  report_failure($sformatf("retire came %0d cycles after the acknowledge",
                                           cycles));
               end
               compare_retire(o_retire, exp_ret);
            end
         end else if (o_ibus_cyc) begin
            seen = 1'b1;
            if (want_retire) begin
               report_failure("next fetch started without a retire pulse");
            end else if (cycles != RETIRE_LAT + 1) begin
               report_failure($sformatf("next fetch came %0d cycles after the acknowledge",
                                        cycles));
            end
         end
      end
      if (!seen) begin
         $display("Timeout: test %0d saw neither a retire nor the next fetch", idx);
         failed++;
         aborted = 1'b1;
         return;
      end

      if (errors == errors_before) begin
         passed++;
         $display("test %0d word %h: pass", idx, word);
      end else begin
         failed++;
         $display("test %0d word %h: FAIL", idx, word);
      end
   endtask

   initial begin
      i_reset    = 1'b1;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      lfsr       = 32'h1ff3_8bb9;
      errors     = 0;
      passed     = 0;
      failed     = 0;
      aborted    = 1'b0;

      // Flag column of an unloaded row stays above 1
      for (int k = 0; k < NUM_TESTS*FIELDS; k++) begin
         stim[k] = 32'hf000_0000 | 32'(k);
      end
      $readmemh("tb/bitser_stimulus.txt", stim);
      for (int k = 0; k < NUM_TESTS; k++) begin
         if (stim[k*FIELDS+1] > 32'd1) begin
            aborted = 1'b1;
         end
      end
      if (aborted) begin
         $display("Stimulus file tb/bitser_stimulus.txt is missing or short");
      end

      repeat (10) @(posedge clk);
      i_reset <= 1'b0;

      for (int i = 0; i < NUM_TESTS && !aborted; i++) begin
         run_test(i);
      end

      $display("%0d passed, %0d failed, %0d errors", passed, failed, errors);
      if (errors == 0 && !aborted && passed == NUM_TESTS) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* tb/bitser_stimulus.txt */
// Columns: instruction word, retire expected (1 or 0), rd, rd value after retire
// One row per test in fetch order from the reset address
00500093 1 01 00000005 // addi x1, x0, 5
FFD00113 1 02 FFFFFFFD // addi x2, x0, -3
FF808193 1 03 FFFFFFFD // addi x3, x1, -8
80000237 1 04 80000000 // lui x4, 0x80000
FFF20213 1 04 7FFFFFFF // addi x4, x4, -1
001202B3 1 05 80000004 // add x5, x4, x1
00210333 1 06 FFFFFFFA // add x6, x2, x2
402083B3 1 07 00000008 // sub x7, x1, x2
40100433 1 08 FFFFFFFB // sub x8, x0, x1
401284B3 1 09 7FFFFFFF // sub x9, x5, x1
12345537 1 0A 12345000 // lui x10, 0x12345
67850513 1 0A 12345678 // addi x10, x10, 0x678
002545B3 1 0B EDCBA985 // xor x11, x10, x2
00156633 1 0C 1234567D // or x12, x10, x1
0085F6B3 1 0D EDCBA981 // and x13, x11, x8
00708013 0 00 00000000 // addi x0, x1, 7
00109093 0 00 00000000 // slli x1, x1, 1 is not supported
00100733 1 0E 00000005 // add x14, x0, x1
400387B3 1 0F 00000008 // sub x15, x7, x0
00000833 1 10 00000000 // add x16, x0, x0

/* bitser.f */
design/bitser_pkg.sv
design/bitser_state.sv
design/bitser_count.sv
design/bitser_decode.sv
design/bitser_alu.sv
design/bitser_regfile.sv
design/bitser_top.sv
tb/bitser_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := bitser_tb
FILELIST  := bitser.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := all tests passed

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
